//--- design/intt_pkg.sv
// ring constants and shared types for the 16-point INTT engine; Q, roots and widths are fixed here
package intt_pkg;

    // ring parameters
    localparam int RING_SIZE  = 16;                   // coefficients per polynomial
    localparam int RING_DEPTH = $clog2(RING_SIZE);    // butterfly stages
    localparam int COEF_W     = 13;                   // bits per coefficient
    localparam int Q          = 7681;                 // prime modulus, Q-1 divisible by 2*RING_SIZE

    // 7098 is the inverse of 7154, which has order 16 mod Q
    localparam logic [COEF_W-1:0] OMEGA_INV = 13'd7098;
    localparam logic [COEF_W-1:0] N_INV     = 13'd7201;   // 16 * 7201 = 1 mod Q

    // addressing
    localparam int ADDR_W    = RING_DEPTH;        // coefficient address
    localparam int TW_ADDR_W = RING_DEPTH - 1;    // twiddle index, RING_SIZE/2 entries

    // latencies in cycles
    localparam int BF_LATENCY = 3;    // mul, reduce, add/sub
    localparam int RD_LATENCY = 1;    // memory and rom read

    // modular reduction
    localparam int PROD_W    = 2 * COEF_W;                // full product width
    localparam int BARRETT_K = PROD_W;
    localparam int BARRETT_M = (1 << BARRETT_K) / Q;      // floor(2^k / Q)

    // scheduling
    // idle gap after each stage so the last write lands before the next stage reads
    localparam int DRAIN_CYCLES = BF_LATENCY + RD_LATENCY + 1;
    localparam int DRAIN_W      = $clog2(DRAIN_CYCLES);
    localparam int STAGE_W      = $clog2(RING_DEPTH + 1); // stages plus the scaling pass

    typedef logic [COEF_W-1:0] coef_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // command FSM of the core
    typedef enum logic [2:0] {
        ST_IDLE,     // waiting for a strobe
        ST_LOAD,     // serial coefficient load
        ST_RUN,      // butterfly stages
        ST_SCALE,    // multiply by N_INV
        ST_READ      // serial readout
    } core_state_e;

    // one butterfly issue from the address generator
    typedef struct packed {
        logic                 valid;
        addr_t                addr_a;    // even leg, or the only operand when scaling
        addr_t                addr_b;    // odd leg, span apart
        logic [TW_ADDR_W-1:0] tw_idx;
        logic                 scale;     // final pass, w forced to N_INV
    } bf_op_t;

    // one butterfly result, written back in place
    typedef struct packed {
        logic  valid;
        addr_t addr_a;
        addr_t addr_b;
        coef_t res_a;    // u + w*v
        coef_t res_b;    // u - w*v
    } bf_res_t;

endpackage

//--- design/coef_ram.sv
// coefficient store: two writes and two reads per cycle, reads registered, port b wins on collision
`timescale 1ns/100ps

module coef_ram (
    input  logic            clk,
    input  logic            we_a,
    input  logic            we_b,
    input  intt_pkg::addr_t waddr_a,
    input  intt_pkg::addr_t waddr_b,
    input  intt_pkg::coef_t wdata_a,
    input  intt_pkg::coef_t wdata_b,
    input  intt_pkg::addr_t raddr_a,
    input  intt_pkg::addr_t raddr_b,
    output intt_pkg::coef_t rdata_a,
    output intt_pkg::coef_t rdata_b
);
    import intt_pkg::*;

    coef_t mem [RING_SIZE];    // one bank, read port duplicated

    // write side
    always_ff @(posedge clk) begin
        if (we_a) begin
            mem[waddr_a] <= wdata_a;
        end
        if (we_b) begin
            mem[waddr_b] <= wdata_b;    // later assignment, so b overrides a
        end
    end

    // read side, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdata_a <= mem[raddr_a];
        rdata_b <= mem[raddr_b];
    end

endmodule

//--- design/twiddle_rom.sv
// inverse twiddle table OMEGA_INV^k mod Q for k < RING_SIZE/2, built at elaboration, 1-cycle read
`timescale 1ns/100ps

module twiddle_rom (
    input  logic                            clk,
    input  logic [intt_pkg::TW_ADDR_W-1:0]  idx,
    output intt_pkg::coef_t                 tw
);
    import intt_pkg::*;

    localparam int TW_SIZE = RING_SIZE / 2;

    coef_t tw_table [TW_SIZE];

    // power of the inverse root, evaluated by the elaborator
    function automatic coef_t tw_pow(input int k);
        int acc;
        acc = 1;
        for (int i = 0; i < k; i++) begin
            acc = (acc * int'(OMEGA_INV)) % Q;    // stays below Q*Q, fits in int
        end
        return coef_t'(acc);
    endfunction

    // constant table
    for (genvar k = 0; k < TW_SIZE; k++) begin : g_tw
        localparam coef_t TW_K = tw_pow(k);
        assign tw_table[k] = TW_K;
    end

    // registered read, lines up with coef_ram
    always_ff @(posedge clk) begin
        tw <= tw_table[idx];
    end

endmodule

//--- design/butterfly_unit.sv
// 3-stage CT butterfly mod Q; inputs must be reduced (< Q); scale ops give N_INV*v on res_a
`timescale 1ns/100ps

module butterfly_unit (
    input  logic              clk,
    input  logic              reset,
    input  intt_pkg::bf_op_t  op_in,
    input  intt_pkg::coef_t   u,
    input  intt_pkg::coef_t   v,
    input  intt_pkg::coef_t   w,
    output intt_pkg::bf_res_t res_out
);
    import intt_pkg::*;

    logic [BF_LATENCY-1:0] vld_pipe;    // valid travels with the data

    coef_t                 w_eff, u_eff;
    logic [PROD_W-1:0]     prod1;        // stage 1 product
    addr_t                 a1, b1, a2, b2, a3, b3;
    coef_t                 u1, u2, p2;
    coef_t                 res_a3, res_b3;

    logic [PROD_W+COEF_W:0] bar_mul;     // prod * m, < 2^40
    logic [COEF_W:0]        bar_q;       // quotient estimate
    logic [COEF_W+1:0]      bar_r;       // < 2Q
    coef_t                  red;
    logic [COEF_W:0]        sum;
    coef_t                  sum_mod, diff_mod;

    // scaling pass: w = N_INV, u = 0
    assign w_eff = op_in.scale ? N_INV : w;
    assign u_eff = op_in.scale ? '0 : u;

    // barrett reduction of the stage 1 product
    always_comb begin
        bar_mul = prod1 * (PROD_W+COEF_W+1)'(BARRETT_M);
        bar_q   = bar_mul[BARRETT_K +: COEF_W+1];
        bar_r   = (COEF_W+2)'(prod1 - bar_q * Q);     // estimate is at most one low
        red     = (bar_r >= Q) ? coef_t'(bar_r - Q) : coef_t'(bar_r);
    end

    // modular add and subtract
    always_comb begin
        sum      = {1'b0, u2} + {1'b0, p2};
        sum_mod  = (sum >= Q) ? coef_t'(sum - Q) : coef_t'(sum);
        diff_mod = (u2 >= p2) ? coef_t'(u2 - p2) : coef_t'(u2 + Q - p2);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[BF_LATENCY-2:0], op_in.valid};
        end
    end

    // datapath, no reset needed
    always_ff @(posedge clk) begin
        prod1  <= w_eff * v;    // stage 1
        u1     <= u_eff;
        a1     <= op_in.addr_a;
        b1     <= op_in.addr_b;
        p2     <= red;          // stage 2
        u2     <= u1;
        a2     <= a1;
        b2     <= b1;
        res_a3 <= sum_mod;      // stage 3
        res_b3 <= diff_mod;
        a3     <= a2;
        b3     <= b2;
    end

    assign res_out = '{valid: vld_pipe[BF_LATENCY-1], addr_a: a3, addr_b: b3,
                       res_a: res_a3, res_b: res_b3};

endmodule

//--- design/intt_addr_gen.sv
// DIT schedule on bit-reversed data, then one scale op per address; run is ignored while active
`timescale 1ns/100ps

module intt_addr_gen (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    output intt_pkg::bf_op_t op,
    output logic             finished
);
    import intt_pkg::*;

    logic               active;     // a run is in progress
    logic               issuing;    // emitting ops, else draining
    logic [STAGE_W-1:0] stage;      // RING_DEPTH means scaling pass
    addr_t              pair;       // butterfly pair, or address when scaling
    logic [DRAIN_W-1:0] drain;

    logic  scale_pass;
    addr_t last_pair;
    addr_t low_mask;    // bits of j inside the group
    addr_t half;        // span m = 2^stage
    addr_t bf_a;
    logic [TW_ADDR_W-1:0] tw_j;

    assign scale_pass = (stage == STAGE_W'(RING_DEPTH));
    assign last_pair  = scale_pass ? addr_t'(RING_SIZE - 1) : addr_t'(RING_SIZE / 2 - 1);

    always_comb begin
        low_mask = '0;
        half     = '0;
        tw_j     = '0;
        if (!scale_pass) begin
            half     = addr_t'(1) << stage;
            low_mask = half - addr_t'(1);
            // j * RING_SIZE/(2m) == j << (RING_DEPTH-1-stage)
            tw_j = TW_ADDR_W'((pair & low_mask) << (STAGE_W'(RING_DEPTH - 1) - stage));
        end
        bf_a = ((pair & ~low_mask) << 1) | (pair & low_mask);   // zero inserted at bit 'stage'
    end

    always_comb begin
        op.valid  = active && issuing;
        op.scale  = scale_pass;
        op.addr_a = scale_pass ? pair : bf_a;
        op.addr_b = scale_pass ? pair : (bf_a | half);   // a + m, bit is clear in a
        op.tw_idx = tw_j;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            issuing  <= 1'b0;
            stage    <= '0;
            pair     <= '0;
            drain    <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (!active) begin
                if (run) begin
                    active  <= 1'b1;
                    issuing <= 1'b1;
                    stage   <= '0;
                    pair    <= '0;
                end
            end else if (issuing) begin
                if (pair == last_pair) begin
                    issuing <= 1'b0;    // stage issued, let the pipeline empty
                    drain   <= '0;
                end else begin
                    pair <= pair + addr_t'(1);
                end
            end else if (drain == DRAIN_W'(DRAIN_CYCLES - 1)) begin
                if (scale_pass) begin
                    active   <= 1'b0;
                    finished <= 1'b1;   // last scaled value already written
                end else begin
                    stage   <= stage + STAGE_W'(1);
                    pair    <= '0;
                    issuing <= 1'b1;
                end
            end else begin
                drain <= drain + DRAIN_W'(1);
            end
        end
    end

endmodule

//--- design/intt_core.sv
// INTT top: 1-cycle strobes, no back-pressure, strobes outside idle dropped; load > start > read
`timescale 1ns/100ps

module intt_core (
    input  logic            clk,
    input  logic            reset,
    input  logic            load,
    input  logic            start,
    input  logic            read,
    input  intt_pkg::coef_t din,
    output logic            done,
    output logic            dout_valid,
    output intt_pkg::coef_t dout
);
    import intt_pkg::*;

    core_state_e state;
    addr_t       ld_cnt;      // natural index of the incoming coefficient
    addr_t       rd_cnt;      // natural index being read out
    logic        cmd_load, cmd_start, cmd_read;
    logic        ld_fire, rd_fire;
    logic [RD_LATENCY-1:0] rd_pipe;    // read request to data valid

    bf_op_t  op, op_d;
    bf_res_t res;
    logic    finished;

    logic  we_a, we_b;
    addr_t waddr_a, waddr_b, raddr_a, raddr_b;
    coef_t wdata_a, wdata_b, rdata_a, rdata_b;
    coef_t tw, bf_v;

    function automatic addr_t bit_rev(input addr_t a);
        addr_t r;
        for (int i = 0; i < ADDR_W; i++) begin
            r[i] = a[ADDR_W-1-i];
        end
        return r;
    endfunction

    // strobes only count in idle
    assign cmd_load  = (state == ST_IDLE) && load;
    assign cmd_start = (state == ST_IDLE) && start && !load;
    assign cmd_read  = (state == ST_IDLE) && read && !load && !start;

    assign ld_fire = cmd_load || (state == ST_LOAD);    // first word rides with the strobe
    assign rd_fire = cmd_read || (state == ST_READ);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= ST_IDLE;
            ld_cnt <= '0;
            rd_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_load) begin
                        state  <= ST_LOAD;
                        ld_cnt <= ld_cnt + addr_t'(1);
                    end else if (cmd_start) begin
                        state <= ST_RUN;
                    end else if (cmd_read) begin
                        state  <= ST_READ;
                        rd_cnt <= rd_cnt + addr_t'(1);
                    end
                end
                ST_LOAD: begin
                    ld_cnt <= ld_cnt + addr_t'(1);    // wraps back to 0
                    if (ld_cnt == addr_t'(RING_SIZE - 1)) state <= ST_IDLE;
                end
                ST_RUN: begin
                    if (op.valid && op.scale) state <= ST_SCALE;   // stages drained
                end
                ST_SCALE: begin
                    if (finished) state <= ST_IDLE;
                end
                ST_READ: begin
                    rd_cnt <= rd_cnt + addr_t'(1);
                    if (rd_cnt == addr_t'(RING_SIZE - 1)) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // memory port muxing
    always_comb begin
        raddr_a = rd_fire ? rd_cnt : op.addr_a;
        raddr_b = op.addr_b;
        we_a    = res.valid;
        waddr_a = res.addr_a;
        wdata_a = res.res_a;
        if (ld_fire) begin
            we_a    = 1'b1;
            waddr_a = bit_rev(ld_cnt);    // stored bit-reversed for the DIT schedule
            wdata_a = din;
        end
        we_b    = res.valid && (state != ST_SCALE);    // scaling writes a only
        waddr_b = res.addr_b;
        wdata_b = res.res_b;
    end

    // op lines up with the registered operands
    always_ff @(posedge clk or posedge reset) begin
        if (reset) op_d <= '0;
        else       op_d <= op;
    end

    assign bf_v = op_d.scale ? rdata_a : rdata_b;    // scale operand comes from port a

    // status and output, registered
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done       <= 1'b0;
            rd_pipe    <= '0;
            dout_valid <= 1'b0;
            dout       <= '0;
        end else begin
            done       <= finished;
            rd_pipe    <= (rd_pipe << 1) | RD_LATENCY'(rd_fire);
            dout_valid <= rd_pipe[RD_LATENCY-1];
            dout       <= rd_pipe[RD_LATENCY-1] ? rdata_a : '0;
        end
    end

    coef_ram u_ram (
        .clk(clk), .we_a(we_a), .we_b(we_b),
        .waddr_a(waddr_a), .waddr_b(waddr_b), .wdata_a(wdata_a), .wdata_b(wdata_b),
        .raddr_a(raddr_a), .raddr_b(raddr_b), .rdata_a(rdata_a), .rdata_b(rdata_b)
    );

    twiddle_rom u_rom (.clk(clk), .idx(op.tw_idx), .tw(tw));

    butterfly_unit u_bf (
        .clk(clk), .reset(reset), .op_in(op_d),
        .u(rdata_a), .v(bf_v), .w(tw), .res_out(res)
    );

    intt_addr_gen u_agen (
        .clk(clk), .reset(reset), .run(cmd_start), .op(op), .finished(finished)
    );

endmodule

//--- test/intt_assert.sv
// protocol checks bound into intt_core; assumes a new read is issued only after dout_valid falls
`timescale 1ns/100ps

module intt_assert (
    input logic clk,
    input logic reset,
    input logic done,
    input logic dout_valid
);
    import intt_pkg::*;

    logic [ADDR_W:0] vld_len;    // cycles dout_valid has been high so far

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vld_len <= '0;
        end else if (dout_valid) begin
            vld_len <= vld_len + 1'b1;
        end else begin
            vld_len <= '0;    // burst over
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done high for two consecutive cycles");

    // no burst longer than RING_SIZE
    a_valid_max: assert property (@(posedge clk) disable iff (reset)
        dout_valid |-> vld_len < (ADDR_W+1)'(RING_SIZE))
        else $error("dout_valid high for more than RING_SIZE cycles");

    // and none shorter
    a_valid_len: assert property (@(posedge clk) disable iff (reset)
        $fell(dout_valid) |-> vld_len == (ADDR_W+1)'(RING_SIZE))
        else $error("dout_valid burst shorter than RING_SIZE cycles");

    a_no_overlap: assert property (@(posedge clk) disable iff (reset) !(done && dout_valid))
        else $error("done raised during a readout");

endmodule

bind intt_core intt_assert u_assert (
    .clk(clk), .reset(reset), .done(done), .dout_valid(dout_valid)
);

//--- test/intt_tb.sv
// self-checking testbench for intt_core; fixed seed, direct O(N^2) model, 100 ns clock
`timescale 1ns/100ps

module intt_tb;
    import intt_pkg::*;

    // worst case run length from start to done
    localparam int RUN_BOUND = RING_DEPTH * (RING_SIZE/2 + BF_LATENCY + RD_LATENCY + 1)
                               + RING_SIZE + BF_LATENCY + 8;
    localparam int TEST_CYCLES = RING_SIZE + RUN_BOUND + RING_SIZE + 4;    // load, run, readout
    localparam int NUM_TESTS   = 15;
    localparam int WATCHDOG    = 2 * (16 + NUM_TESTS * TEST_CYCLES);       // in clock cycles

    logic  clk, reset, load, start, read, done, dout_valid;
    coef_t din, dout;

    int    seed = 32'hf13f_5cbc;
    int    errors, checks, tests, failed_tests, test_err_base;
    coef_t vec [RING_SIZE];        // stimulus, natural order
    coef_t exp_vec [RING_SIZE];    // expected readout

    intt_core UUT (
        .clk(clk), .reset(reset), .load(load), .start(start), .read(read),
        .din(din), .done(done), .dout_valid(dout_valid), .dout(dout)
    );

    always #50 clk = ~clk;

    function automatic int pow_mod(input int base, input int e);
        int acc;
        acc = 1;
        for (int k = 0; k < e; k++) begin
            acc = (acc * base) % Q;    // both below Q, product fits in int
        end
        return acc;
    endfunction

    // y[i] = N^-1 * sum_j a[j] * w^-(ij), straight from the definition
    task automatic model_intt(input coef_t a [RING_SIZE], output coef_t y [RING_SIZE]);
        int acc;
        for (int i = 0; i < RING_SIZE; i++) begin
            acc = 0;
            for (int j = 0; j < RING_SIZE; j++) begin
                acc = (acc + int'(a[j]) * pow_mod(int'(OMEGA_INV), (i * j) % RING_SIZE)) % Q;
            end
            y[i] = coef_t'((acc * int'(N_INV)) % Q);
        end
    endtask

    task automatic check_coef(input string name, input coef_t expected, input coef_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_err_base) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAILED with %0d errors", name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    task automatic random_vector();
        int r;
        for (int i = 0; i < RING_SIZE; i++) begin
            r = $random(seed);
            vec[i] = coef_t'(((r % Q) + Q) % Q);    // $random is signed
        end
    endtask

    task automatic load_vector();
        for (int i = 0; i < RING_SIZE; i++) begin
            @(posedge clk);
            load <= (i == 0);    // strobe rides with coefficient 0
            din  <= vec[i];
        end
        @(posedge clk);
        din <= '0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // done must show up within the bound, one cycle wide, with no readout meanwhile
    task automatic wait_for_done();
        int n;
        n = 0;
        while (done !== 1'b1 && n < RUN_BOUND) begin
            @(negedge clk);
            check_bit("dout_valid", 1'b0, dout_valid);
            n++;
        end
        if (done !== 1'b1) begin
            errors++;
            $display("done did not arrive within %0d cycles of start", RUN_BOUND);
        end else begin
            @(negedge clk);
            check_bit("done", 1'b0, done);
        end
    endtask

    // read strobe, RD_LATENCY quiet cycles, then RING_SIZE words in natural order
    task automatic read_and_check();
        @(posedge clk);
        read <= 1'b1;
        @(posedge clk);
        read <= 1'b0;
        for (int c = 0; c < RD_LATENCY; c++) begin
            @(negedge clk);
            check_bit("dout_valid", 1'b0, dout_valid);
        end
        for (int i = 0; i < RING_SIZE; i++) begin
            @(negedge clk);
            check_bit("dout_valid", 1'b1, dout_valid);
            check_coef($sformatf("dout[%0d]", i), exp_vec[i], dout);
        end
        @(negedge clk);
        check_bit("dout_valid", 1'b0, dout_valid);
        check_coef("dout", '0, dout);    // output cleared between words
    endtask

    task automatic run_transform();
        load_vector();
        pulse_start();
        wait_for_done();
        read_and_check();
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        load = 1'b0;
        start = 1'b0;
        read = 1'b0;
        din = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        test_err_base = 0;

        // ring constants, order 16 means w^16 = 1 and w^8 != 1
        if (pow_mod(int'(OMEGA_INV), RING_SIZE) != 1 ||
            pow_mod(int'(OMEGA_INV), RING_SIZE / 2) == 1) begin
            errors++;
            $display("OMEGA_INV does not have order exactly %0d modulo Q", RING_SIZE);
        end
        if ((int'(N_INV) * RING_SIZE) % Q != 1) begin
            errors++;
            $display("N_INV is not the inverse of %0d modulo Q", RING_SIZE);
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        repeat (8) begin    // quiet after reset
            @(negedge clk);
            check_bit("done", 1'b0, done);
            check_bit("dout_valid", 1'b0, dout_valid);
            check_coef("dout", '0, dout);
        end
        report_test("reset");

        random_vector();
        model_intt(vec, exp_vec);
        run_transform();
        report_test("single");

        for (int k = 0; k < 8; k++) begin
            random_vector();
            model_intt(vec, exp_vec);
            run_transform();
            report_test($sformatf("repeat_%0d", k));
        end

        vec = '{default: '0};
        model_intt(vec, exp_vec);
        run_transform();
        report_test("all_zero");

        vec = '{default: coef_t'(Q - 1)};
        model_intt(vec, exp_vec);
        run_transform();
        report_test("all_q_minus_1");

        vec = '{default: '0};
        vec[0] = coef_t'(1);
        exp_vec = '{default: N_INV};    // flat spectrum scaled by N^-1
        run_transform();
        report_test("impulse");

        // strobes during a run must not disturb it
        random_vector();
        model_intt(vec, exp_vec);
        load_vector();
        pulse_start();
        repeat (3) @(posedge clk);
        load <= 1'b1;
        din  <= coef_t'(Q - 1);
        @(posedge clk);
        load <= 1'b0;
        read <= 1'b1;
        @(posedge clk);
        read <= 1'b0;
        din  <= '0;
        wait_for_done();
        read_and_check();
        report_test("ignored_cmds");

        random_vector();
        model_intt(vec, exp_vec);
        run_transform();
        read_and_check();    // second readout sees the same memory
        report_test("double_read");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // hard stop at twice the expected length
    initial begin
        #(WATCHDOG * 100);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- project.f
design/intt_pkg.sv
design/coef_ram.sv
design/twiddle_rom.sv
design/butterfly_unit.sv
design/intt_addr_gen.sv
design/intt_core.sv
test/intt_assert.sv
test/intt_tb.sv

//--- Makefile
# Verilator build and run of the INTT testbench

TOP       ?= intt_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= Test failures found

.PHONY: sim clean

# a nonzero exit also covers a failed assertion that stopped the run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
